// ==== common/elink_clk_cfg.svh ====
// Sizing constants, APB register map and reset values for the link clock block
// Include this wherever a width, an address or a reset value is needed

`ifndef ELINK_CLK_CFG_SVH
`define ELINK_CLK_CFG_SVH

// ##########################################################
// Heartbeat and divider sizing
// ##########################################################

`define ELINK_RCW 4              // Heartbeat counter width, one pulse per 16 cycles
`define ELINK_DIVW 3             // Divider ratio field width

// ##########################################################
// APB register map
// ##########################################################

`define ELINK_ADDR_CFG 4'h0      // CFG, read-write
`define ELINK_ADDR_STATUS 4'h4   // STATUS, read-only

// CFG layout
//    bit 0     elink enable
//    bits 3:1  cclk ratio
//    bits 6:4  lclk ratio
`define ELINK_CFG_RESET 7'b000_001_0  // Disabled, cclk_div 1, lclk_div 0

`endif

// ==== common/elink_clk_pkg.sv ====
// Shared types for the link clock and reset block
// Holds the sequencer state codes and the structs carried between blocks

`include "elink_clk_cfg.svh"

package elink_clk_pkg;

   // ##########################################################
   // Reset sequencer states
   // ##########################################################

   typedef enum logic [2:0] {
      RESET_ALL      = 3'd0,  // Everything held
      START_CCLK     = 3'd1,  // PLL out of reset, core clock running
      STOP_CCLK      = 3'd2,  // Quiet time before chip reset release
      START_EPIPHANY = 3'd3,  // Chip reset released, cclk still stopped
      HOLD_IT        = 3'd4,  // Wait for lock again
      ACTIVE         = 3'd5   // Link running
   } reset_state_e;

   // Mirrors CFG bits 6:4, 3:1 and 0
   // First member is the MSB
   typedef struct packed {
      logic [`ELINK_DIVW-1:0] lclk_div;  // Bits 6:4
      logic [`ELINK_DIVW-1:0] cclk_div;  // Bits 3:1
      logic                   elink_en;  // Bit 0
   } clk_cfg_t;

   // Decoded reset controls
   typedef struct packed {
      logic pll_reset;     // Clock generation held
      logic idelay_reset;  // Delay line held
      logic cclk_reset;    // Core clock stopped
      logic e_resetb;      // Chip reset, active low
      logic elink_reset;   // Link logic held
   } rst_ctrl_t;

   // ##########################################################
   // APB
   // ##########################################################

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;   // Byte address
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pslverr;
   } apb_rsp_t;

endpackage

// ==== reset_seq/reset_sequencer.sv ====
// Slow, deterministic reset sequencer for the link clocking
// A free-running heartbeat paces six states from full reset to active
// Reset controls come out as registers aligned with the state register

`timescale 1ns/1ps
`include "elink_clk_cfg.svh"

module reset_sequencer
   import elink_clk_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset_in,
   input  logic         elink_en_i,    // Link enable from CFG
   input  logic         pll_locked_i,  // Asynchronous lock
   output rst_ctrl_t    rst_ctrl_o,
   output reset_state_e state_o,
   output logic         lock_sync_o
);

   logic [`ELINK_RCW-1:0] hb_cnt;       // Free-running wrap counter
   logic                  heartbeat;    // One cycle in 2**RCW

   logic                  rst_req_meta;
   logic                  rst_req_sync;
   logic                  lock_meta;
   logic                  lock_sync;

   reset_state_e          state_q;
   reset_state_e          state_nxt;
   rst_ctrl_t             rst_ctrl_q;

   // Control decode per state
   function automatic rst_ctrl_t decode_ctrl(input reset_state_e st);
      rst_ctrl_t c;
      c.pll_reset    = (st == RESET_ALL);
      c.idelay_reset = (st == RESET_ALL) || (st == START_CCLK);
      c.cclk_reset   = (st == STOP_CCLK) || (st == START_EPIPHANY);
      c.e_resetb     = (st == START_EPIPHANY) || (st == HOLD_IT) || (st == ACTIVE);
      c.elink_reset  = (st != ACTIVE);
      return c;
   endfunction

   // ##########################################################
   // Heartbeat
   // ##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;   // Wraps
         heartbeat <= (hb_cnt == '0);  // Pulse once per wrap
      end
   end

   // ##########################################################
   // Two-flop synchronizers
   // ##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         rst_req_meta <= 1'b1;  // Request asserted out of reset
         rst_req_sync <= 1'b1;
         lock_meta    <= 1'b0;
         lock_sync    <= 1'b0;
      end
      else
      begin
         rst_req_meta <= ~elink_en_i;  // reset_in side is covered by the branch above
         rst_req_sync <= rst_req_meta;
         lock_meta    <= pll_locked_i;
         lock_sync    <= lock_meta;
      end
   end

   // ##########################################################
   // State machine
   // ##########################################################

   always_comb
   begin
      state_nxt = state_q;
      if (rst_req_sync)
         state_nxt = RESET_ALL;              // Request wins over heartbeat
      else if (heartbeat)
      begin
         case (state_q)
            RESET_ALL:      state_nxt = START_CCLK;
            START_CCLK:     if (lock_sync) state_nxt = STOP_CCLK;
            STOP_CCLK:      state_nxt = START_EPIPHANY;
            START_EPIPHANY: state_nxt = HOLD_IT;
            HOLD_IT:        if (lock_sync) state_nxt = ACTIVE;
            ACTIVE:         state_nxt = ACTIVE;  // Until next request
            default:        state_nxt = RESET_ALL;
         endcase
      end
   end

   // Controls decoded from next state, so they line up with state_q
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         state_q    <= RESET_ALL;
         rst_ctrl_q <= decode_ctrl(RESET_ALL);
      end
      else
      begin
         state_q    <= state_nxt;
         rst_ctrl_q <= decode_ctrl(state_nxt);
      end
   end

   assign state_o     = state_q;
   assign rst_ctrl_o  = rst_ctrl_q;
   assign lock_sync_o = lock_sync;

endmodule

// ==== verilog/clock_divider.sv ====
// Behavioral power-of-two clock divider standing in for a PLL output
// Ratio d gives a period of 2**(d+1) sys_clk cycles at 50% duty
// clk90_o trails clk_o by a quarter period, equal to clk_o at d of 0

`timescale 1ns/1ps
`include "elink_clk_cfg.svh"

module clock_divider
(
   input  logic                   sys_clk,
   input  logic                   reset_in,
   input  logic                   hold_i,   // Stop, outputs low
   input  logic [`ELINK_DIVW-1:0] div_i,    // Ratio, taken at next rise
   output logic                   clk_o,
   output logic                   clk90_o
);

   localparam int CW = 2 ** `ELINK_DIVW;  // Counter covers the longest period

   logic [`ELINK_DIVW-1:0] div_q;         // Latched ratio
   logic [CW-1:0]          cnt;           // Position in period
   logic [`ELINK_DIVW:0]   shamt;
   logic [CW:0]            period;
   logic [CW-1:0]          last;          // Final count of period
   logic [CW-1:0]          half;
   logic [CW-1:0]          quarter;

   // ##########################################################
   // Period arithmetic from latched ratio
   // ##########################################################

   always_comb
   begin
      shamt   = {1'b0, div_q} + 1'b1;
      period  = (CW+1)'(1) << shamt;
      last    = CW'(period - 1'b1);
      half    = CW'(period >> 1);
      quarter = CW'(period >> 2);    // Zero at d of 0
   end

   // ##########################################################
   // Counter and outputs
   // ##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in || hold_i)
      begin
         cnt     <= '0;
         clk_o   <= 1'b0;
         clk90_o <= 1'b0;
         div_q   <= div_i;           // Fresh ratio on release
      end
      else
      begin
         cnt <= (cnt == last) ? '0 : cnt + 1'b1;

         if (cnt == '0)
         begin
            clk_o <= 1'b1;           // Rising edge
            div_q <= div_i;          // New ratio from this period on
         end
         else if (cnt == half)
            clk_o <= 1'b0;

         if (cnt == quarter)
            clk90_o <= 1'b1;
         else if (cnt == CW'(quarter + half))
            clk90_o <= 1'b0;
      end
   end

endmodule

// ==== verilog/clk_apb_regs.sv ====
// Zero-wait APB register block for the link clock block
// CFG at 0x0 holds enable and divider ratios, STATUS at 0x4 reports
// sequencer state, synchronized lock and link reset

`timescale 1ns/1ps
`include "elink_clk_cfg.svh"

module clk_apb_regs
   import elink_clk_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset_in,
   input  apb_req_t     apb_req_i,
   input  reset_state_e state_i,
   input  logic         lock_sync_i,
   input  logic         elink_reset_i,
   output apb_rsp_t     apb_rsp_o,
   output clk_cfg_t     cfg_o
);

   logic     access;     // Access phase
   logic     wr_en;
   logic     rd_en;
   logic     hit_cfg;
   logic     hit_status;
   logic     bad_access; // Unmapped, or write to STATUS
   clk_cfg_t cfg_q;

   // ##########################################################
   // Decode
   // ##########################################################

   assign access     = apb_req_i.psel && apb_req_i.penable;
   assign wr_en      = access && apb_req_i.pwrite;
   assign rd_en      = access && !apb_req_i.pwrite;
   assign hit_cfg    = (apb_req_i.paddr == `ELINK_ADDR_CFG);
   assign hit_status = (apb_req_i.paddr == `ELINK_ADDR_STATUS);

   always_comb
   begin
      bad_access = 1'b0;
      if (access)
      begin
         if (!hit_cfg && !hit_status)
            bad_access = 1'b1;      // No register there
         else if (hit_status && apb_req_i.pwrite)
            bad_access = 1'b1;      // STATUS is read-only
      end
   end

   // ##########################################################
   // CFG register
   // ##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
         cfg_q <= clk_cfg_t'(`ELINK_CFG_RESET);
      else if (wr_en && hit_cfg)
         cfg_q <= clk_cfg_t'(apb_req_i.pwdata[6:0]);  // Upper bits dropped
   end

   // ##########################################################
   // Read data, valid in the access cycle
   // ##########################################################

   always_comb
   begin
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pslverr = bad_access;
      if (rd_en)
      begin
         if (hit_cfg)
            apb_rsp_o.prdata = {25'd0, cfg_q};
         else if (hit_status)
            apb_rsp_o.prdata = {27'd0, elink_reset_i, lock_sync_i, state_i};
      end
   end

   assign cfg_o = cfg_q;

endmodule

// ==== verilog/elink_clocks_top.sv ====
// Top of the link clock and reset block
// Register block sets enable and ratios, the sequencer walks the reset
// states and three dividers make cclk, lclk with lclk90, and lclk_div4

`timescale 1ns/1ps
`include "elink_clk_cfg.svh"

module elink_clocks_top
   import elink_clk_pkg::*;
(
   input  logic     sys_clk,
   input  logic     reset_in,
   input  apb_req_t apb_req_i,
   input  logic     pll_locked_i,   // Asynchronous
   output apb_rsp_t apb_rsp_o,
   output logic     cclk_o,         // Core clock
   output logic     lclk_o,         // Link clock
   output logic     lclk90_o,       // Link clock, 90 degrees
   output logic     lclk_div4_o,    // Parallel clock
   output logic     e_resetb_o,     // Chip reset, active low
   output logic     elink_reset_o   // Link logic reset
);

   clk_cfg_t               cfg;
   rst_ctrl_t              rst_ctrl;
   reset_state_e           state;
   logic                   lock_sync;
   logic [`ELINK_DIVW-1:0] div4_ratio;  // Four times the lclk period

   // Wraps for lclk_div above 5
   assign div4_ratio = cfg.lclk_div + `ELINK_DIVW'(2);

   reset_sequencer reset_sequencer0 (
      .sys_clk      (sys_clk),
      .reset_in     (reset_in),
      .elink_en_i   (cfg.elink_en),
      .pll_locked_i (pll_locked_i),
      .rst_ctrl_o   (rst_ctrl),
      .state_o      (state),
      .lock_sync_o  (lock_sync)
   );

   clk_apb_regs clk_apb_regs0 (
      .sys_clk       (sys_clk),
      .reset_in      (reset_in),
      .apb_req_i     (apb_req_i),
      .state_i       (state),
      .lock_sync_i   (lock_sync),
      .elink_reset_i (rst_ctrl.elink_reset),
      .apb_rsp_o     (apb_rsp_o),
      .cfg_o         (cfg)
   );

   // ##########################################################
   // Dividers
   // ##########################################################

   clock_divider cclk_div0 (         // Stopped around chip reset release
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .hold_i   (rst_ctrl.pll_reset || rst_ctrl.cclk_reset),
      .div_i    (cfg.cclk_div),
      .clk_o    (cclk_o),
      .clk90_o  ()
   );

   clock_divider lclk_div0 (
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .hold_i   (rst_ctrl.pll_reset),
      .div_i    (cfg.lclk_div),
      .clk_o    (lclk_o),
      .clk90_o  (lclk90_o)
   );

   clock_divider lclk_div4_div0 (
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .hold_i   (rst_ctrl.pll_reset),
      .div_i    (div4_ratio),
      .clk_o    (lclk_div4_o),
      .clk90_o  ()
   );

   assign e_resetb_o    = rst_ctrl.e_resetb;
   assign elink_reset_o = rst_ctrl.elink_reset;

endmodule

// ==== bench/tb_clkgen.sv ====
// Clock and reset source for the link clock testbench
// 4 ns sys_clk, synchronous reset held for the first 5 rising edges

`timescale 1ns/1ps

module tb_clkgen
(
   output logic sys_clk_o,
   output logic reset_o
);

   initial
   begin
      sys_clk_o = 1'b0;
      forever #2 sys_clk_o = ~sys_clk_o;  // 2 ns half period
   end

   initial
   begin
      reset_o = 1'b1;
      repeat (5) @(posedge sys_clk_o);
      reset_o <= 1'b0;                    // Released on a rising edge
   end

endmodule

// ==== bench/elink_clocks_properties.sv ====
// Concurrent checks on the reset sequencer, attached by bind
// Covers heartbeat pacing and the legal combinations of reset controls

`timescale 1ns/1ps

module elink_clocks_properties
   import elink_clk_pkg::*;
(
   input logic         sys_clk,
   input logic         reset_in,
   input logic         heartbeat_i,
   input logic         rst_req_i,    // Synchronized reset request
   input reset_state_e state_i,
   input rst_ctrl_t    rst_ctrl_i
);

   // State moves only after a heartbeat or a reset request
   state_paced: assert property (
      @(posedge sys_clk) disable iff (reset_in)
      (state_i != $past(state_i)) |-> ($past(heartbeat_i) || $past(rst_req_i))
   ) else $error("sequencer state changed outside a heartbeat or reset request");

   // Link released only with the chip out of reset
   link_after_chip: assert property (
      @(posedge sys_clk) disable iff (reset_in)
      !rst_ctrl_i.elink_reset |-> rst_ctrl_i.e_resetb
   ) else $error("elink_reset low while e_resetb low");

   cclk_pll_exclusive: assert property (
      @(posedge sys_clk) disable iff (reset_in)
      !(rst_ctrl_i.cclk_reset && rst_ctrl_i.pll_reset)
   ) else $error("cclk_reset and pll_reset active together");

endmodule

bind reset_sequencer elink_clocks_properties props0 (
   .sys_clk     (sys_clk),
   .reset_in    (reset_in),
   .heartbeat_i (heartbeat),
   .rst_req_i   (rst_req_sync),
   .state_i     (state_q),
   .rst_ctrl_i  (rst_ctrl_q)
);

// ==== bench/elink_clocks_tb.sv ====
// Testbench for the link clock and reset block
// Drives APB and PLL lock, polls STATUS through the sequence and
// measures the divided clocks against reference periods

`timescale 1ns/1ps
`include "elink_clk_cfg.svh"

module elink_clocks_tb
   import elink_clk_pkg::*;
();

   localparam int HB_LEN  = 1 << `ELINK_RCW;      // Cycles per heartbeat
   localparam int N_REG   = 6;
   localparam int N_DIV   = 4;
   localparam int SEQ_LEN = 8 * HB_LEN + 40;      // One run to ACTIVE
   localparam int T1_LEN  = 4 * HB_LEN + 40;
   localparam int T2_LEN  = N_REG * 8 + 60;
   localparam int T5_LEN  = N_DIV * (9 * 256 + 4 * 64 + 10);
   localparam int LIMIT   = T1_LEN + T2_LEN + 4 * SEQ_LEN + 256 + T5_LEN + 500;

   logic         sys_clk;
   logic         reset_in;
   apb_req_t     apb_req;
   apb_rsp_t     apb_rsp;
   logic         pll_locked;
   logic         cclk;
   logic         lclk;
   logic         lclk90;
   logic         lclk_div4;
   logic         e_resetb;
   logic         elink_reset;

   logic [15:0]  lfsr_q;
   int           checks;
   int           errors;
   int           cycles = 0;
   reset_state_e seen_state;      // Last state polled from STATUS
   logic         eres_smp;        // Port samples taken in each APB access
   logic         eresb_smp;
   logic         eresb_seen;      // e_resetb seen high this run
   logic         cclk_toggled;
   reset_state_e mon_prev;
   logic         cclk_prev;

   tb_clkgen clkgen0 (.sys_clk_o(sys_clk), .reset_o(reset_in));

   elink_clocks_top dut0 (
      .sys_clk       (sys_clk),
      .reset_in      (reset_in),
      .apb_req_i     (apb_req),
      .pll_locked_i  (pll_locked),
      .apb_rsp_o     (apb_rsp),
      .cclk_o        (cclk),
      .lclk_o        (lclk),
      .lclk90_o      (lclk90),
      .lclk_div4_o   (lclk_div4),
      .e_resetb_o    (e_resetb),
      .elink_reset_o (elink_reset)
   );

   // ##########################################################
   // Reference model
   // ##########################################################

   function automatic reset_state_e ref_next_state(input reset_state_e st, input logic hb,
                                                   input logic lock, input logic req);
      if (req)
         return RESET_ALL;
      if (!hb)
         return st;
      case (st)
         RESET_ALL:      return START_CCLK;
         START_CCLK:     return lock ? STOP_CCLK : START_CCLK;
         STOP_CCLK:      return START_EPIPHANY;
         START_EPIPHANY: return HOLD_IT;
         HOLD_IT:        return lock ? ACTIVE : HOLD_IT;
         default:        return ACTIVE;
      endcase
   endfunction

   function automatic rst_ctrl_t ref_ctrl(input reset_state_e st);
      rst_ctrl_t c;
      c.pll_reset    = (st == RESET_ALL);
      c.idelay_reset = st inside {RESET_ALL, START_CCLK};
      c.cclk_reset   = st inside {STOP_CCLK, START_EPIPHANY};
      c.e_resetb     = st inside {START_EPIPHANY, HOLD_IT, ACTIVE};
      c.elink_reset  = (st != ACTIVE);
      return c;
   endfunction

   function automatic int ref_period(input int d);
      return 1 << (d + 1);                         // In sys_clk cycles
   endfunction

   // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
   // One step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // ##########################################################
   // Checker and APB access
   // ##########################################################

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             input logic exp_err, output logic [31:0] rdata);
      apb_req_t r;
      r.psel    = 1'b1;
      r.penable = 1'b0;
      r.pwrite  = wr;
      r.paddr   = addr;
      r.pwdata  = wdata;
      @(posedge sys_clk);
      apb_req <= r;                     // Setup phase
      @(posedge sys_clk);
      apb_req.penable <= 1'b1;          // Access phase
      @(negedge sys_clk);
      rdata     = apb_rsp.prdata;
      eres_smp  = elink_reset;
      eresb_smp = e_resetb;
      check_eq("pslverr", apb_rsp.pslverr, exp_err);
      @(posedge sys_clk);
      apb_req <= '0;
   endtask

   task automatic read_status(output reset_state_e st, output logic lock);
      logic [31:0] d;
      rst_ctrl_t   c;
      apb_access(1'b0, `ELINK_ADDR_STATUS, 32'd0, 1'b0, d);
      st   = reset_state_e'(d[2:0]);
      lock = d[3];
      c    = ref_ctrl(st);
      check_eq("STATUS.elink_reset", d[4], c.elink_reset);
      check_eq("elink_reset_o", eres_smp, c.elink_reset);
      check_eq("e_resetb_o", eresb_smp, c.e_resetb);
   endtask

   // Polls until ACTIVE and checks each new state against the reference
   task automatic poll_sequence(input int max_polls);
      reset_state_e st;
      logic         lock;
      int           n;
      n = 0;
      while (seen_state != ACTIVE && n < max_polls)
      begin
         read_status(st, lock);
         if (st != seen_state)
            check_eq("STATUS.state", st, ref_next_state(seen_state, 1'b1, pll_locked, 1'b0));
         if (!(st inside {RESET_ALL, START_CCLK}))
            check_eq("STATUS.lock", lock, pll_locked);  // Lock held since START_CCLK
         if (!eres_smp)
            check_eq("e_resetb_o high before elink_reset_o low", eresb_seen, 1'b1);
         eresb_seen = eresb_seen | eresb_smp;
         seen_state = st;
         n++;
      end
   endtask

   task automatic wait_reset_all();
      reset_state_e st;
      logic         lock;
      int           n;
      n = 0;
      read_status(st, lock);
      while (st != RESET_ALL && n < 8)
      begin
         read_status(st, lock);
         n++;
      end
      check_eq("STATUS.state after disable", st, RESET_ALL);
      seen_state = st;
      eresb_seen = 1'b0;
   endtask

   // ##########################################################
   // Clock measurement
   // ##########################################################

   function automatic logic clk_pick(input int which);
      case (which)
         0:       return cclk;
         1:       return lclk;
         2:       return lclk_div4;
         default: return lclk90;
      endcase
   endfunction

   // Counts negedge samples up to the next rising edge
   task automatic wait_rise(input int which, output int n);
      logic prev;
      logic cur;
      n    = 0;
      prev = clk_pick(which);
      cur  = prev;
      while (!(cur && !prev) && n < 1024)
      begin
         prev = cur;
         @(negedge sys_clk);
         cur = clk_pick(which);
         n++;
      end
   endtask

   // First rise may still carry the old ratio so the third spacing counts
   task automatic measure_period(input int which, input string name, input int exp);
      int n;
      @(negedge sys_clk);
      wait_rise(which, n);
      wait_rise(which, n);
      wait_rise(which, n);
      check_eq(name, n, exp);
   endtask

   // cclk watch around the stop window
   always @(negedge sys_clk)
   begin
      if (!reset_in)
      begin
         if (dut0.state == START_CCLK && cclk != cclk_prev)
            cclk_toggled = 1'b1;
         if ((dut0.state inside {STOP_CCLK, START_EPIPHANY}) &&
             (mon_prev inside {STOP_CCLK, START_EPIPHANY}) && cclk)
            check_eq("cclk_o while stopped", cclk, 1'b0);
      end
      mon_prev  = dut0.state;
      cclk_prev = cclk;
   end

   always @(posedge sys_clk)
   begin
      cycles = cycles + 1;
      if (cycles > LIMIT)
      begin
         $display("run stopped: cycle limit %0d reached before the tests finished", LIMIT);
         $display("Testbench failed");
         $finish;
      end
   end

   // ##########################################################
   // Tests
   // ##########################################################

   task automatic report_test(input string name, input int err0);
      $display("%s: %0d errors", name, errors - err0);
   endtask

   initial
   begin
      int           err0;
      logic [31:0]  d;
      logic [31:0]  w;
      reset_state_e st;
      logic         lock;
      int           cd;
      int           ld;
      apb_req      = '0;
      pll_locked   = 1'b0;
      lfsr_q       = 16'd29185;
      checks       = 0;
      errors       = 0;
      cclk_toggled = 1'b0;
      eresb_seen   = 1'b0;
      seen_state   = RESET_ALL;
      while (reset_in !== 1'b0)
         @(posedge sys_clk);

      // 1. Reset values with the sequencer parked while disabled
      err0 = errors;
      @(negedge sys_clk);
      check_eq("elink_reset_o", elink_reset, 1'b1);
      check_eq("e_resetb_o", e_resetb, 1'b0);
      check_eq("cclk_o", cclk, 1'b0);
      apb_access(1'b0, `ELINK_ADDR_CFG, 32'd0, 1'b0, d);
      check_eq("CFG", d, 32'(`ELINK_CFG_RESET));
      repeat (3 * HB_LEN) @(posedge sys_clk);
      read_status(st, lock);
      check_eq("STATUS.state", st, RESET_ALL);
      check_eq("STATUS.lock", lock, 1'b0);
      report_test("test 1 reset values", err0);

      // 2. CFG readback and bad accesses with enable kept clear
      err0 = errors;
      for (int i = 0; i < N_REG; i++)
      begin
         w = take_bits(32) & ~32'h1;
         apb_access(1'b1, `ELINK_ADDR_CFG, w, 1'b0, d);
         apb_access(1'b0, `ELINK_ADDR_CFG, 32'd0, 1'b0, d);
         check_eq("CFG", d, w & 32'h7F);
      end
      apb_access(1'b1, 4'h8, take_bits(32), 1'b1, d);
      apb_access(1'b0, 4'h8, 32'd0, 1'b1, d);
      check_eq("prdata at 0x8", d, 32'd0);
      apb_access(1'b1, `ELINK_ADDR_STATUS, 32'hFFFF_FFFF, 1'b1, d);
      apb_access(1'b0, `ELINK_ADDR_CFG, 32'd0, 1'b0, d);
      check_eq("CFG after bad writes", d, w & 32'h7F);
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'(`ELINK_CFG_RESET), 1'b0, d);
      report_test("test 2 registers", err0);

      // 3. Full sequence with lock held
      err0 = errors;
      pll_locked <= 1'b1;
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'h3, 1'b0, d);  // Enable with cclk_div 1
      poll_sequence(SEQ_LEN / 4);
      check_eq("STATUS.state at end", seen_state, ACTIVE);
      check_eq("cclk_o toggled in START_CCLK", cclk_toggled, 1'b1);
      report_test("test 3 sequence with lock", err0);

      // 4. Lock withheld and then raised after a random delay
      err0 = errors;
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'h2, 1'b0, d);
      wait_reset_all();
      pll_locked <= 1'b0;
      repeat (4) @(posedge sys_clk);
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'h3, 1'b0, d);
      poll_sequence(6 * HB_LEN / 4);
      check_eq("STATUS.state without lock", seen_state, START_CCLK);
      check_eq("elink_reset_o without lock", eres_smp, 1'b1);
      repeat (take_bits(8)) @(posedge sys_clk);
      pll_locked <= 1'b1;
      poll_sequence(SEQ_LEN / 4);
      check_eq("STATUS.state after lock", seen_state, ACTIVE);
      report_test("test 4 lock withheld", err0);

      // 5. Divider periods and lclk90 offset at random ratios
      err0 = errors;
      for (int i = 0; i < N_DIV; i++)
      begin
         cd = int'(take_bits(3));
         ld = int'(take_bits(3)) % 6;           // Keeps the div4 ratio in range
         w  = {25'd0, 3'(ld), 3'(cd), 1'b1};
         apb_access(1'b1, `ELINK_ADDR_CFG, w, 1'b0, d);
         measure_period(0, "cclk_o rise spacing", ref_period(cd));
         measure_period(1, "lclk_o rise spacing", ref_period(ld));
         cd = 0;
         while (!lclk90 && cd < 256)
         begin
            @(negedge sys_clk);
            cd++;
         end
         check_eq("lclk90_o delay after lclk_o", cd, ref_period(ld) / 4);
         measure_period(2, "lclk_div4_o rise spacing", ref_period(ld + 2));
      end
      report_test("test 5 divider periods", err0);

      // 6. Disable and run again
      err0 = errors;
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'h2, 1'b0, d);
      wait_reset_all();
      check_eq("elink_reset_o after disable", eres_smp, 1'b1);
      check_eq("e_resetb_o after disable", eresb_smp, 1'b0);
      apb_access(1'b1, `ELINK_ADDR_CFG, 32'h3, 1'b0, d);
      poll_sequence(SEQ_LEN / 4);
      check_eq("STATUS.state after re-enable", seen_state, ACTIVE);
      report_test("test 6 disable and re-enable", err0);

      $display("all tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+common
common/elink_clk_pkg.sv
reset_seq/reset_sequencer.sv
verilog/clock_divider.sv
verilog/clk_apb_regs.sv
verilog/elink_clocks_top.sv
bench/tb_clkgen.sv
bench/elink_clocks_properties.sv
bench/elink_clocks_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports a pass
verilator --binary --timing --assert -f list.f --top-module elink_clocks_tb \
   && ./obj_dir/Velink_clocks_tb | tee /dev/stderr | grep -q "Testbench passed" \
   && echo "simulation run: pass" \
   || { echo "simulation run: fail"; exit 1; }
